// ==== sources.f ====
+incdir+tb
hw/i2c_pkg.sv
hw/i2c_byte_serializer.sv
hw/i2c_reg_target.sv
hw/i2c_reg_slave.sv
tb/tb_i2c_reg_slave.sv

// ==== Makefile ====
# Verilator build, run and lint for the I2C register slave

VERILATOR ?= verilator
TOP ?= tb_i2c_reg_slave
RTL_TOP ?= i2c_reg_slave
FILELIST ?= sources.f
RTL_FILES ?= hw/i2c_pkg.sv hw/i2c_byte_serializer.sv hw/i2c_reg_target.sv hw/i2c_reg_slave.sv
TB_FILES ?= tb/tb_i2c_reg_slave.sv tb/i2c_host_tasks.svh
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VERILATOR_FLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall

FAIL_MSG = *** TEST FAILED ***
PASS_MSG = *** TEST PASSED ***
SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(RTL_FILES) $(TB_FILES)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, a missing pass line counts as failure
run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/i2c_host_tasks.svh ====
// I2C host bit-level tasks and random source

`ifndef I2C_HOST_TASKS_SVH
`define I2C_HOST_TASKS_SVH

`default_nettype none

// Bus pins move only right after a falling clock edge
task automatic hold_clocks(input int count);
	int n;
	for (n = 0; n < count; n++)
		@(negedge clk);
endtask

// SDA falls under a high SCL, then SCL drops for the first bit
task automatic start_condition();
	sda_host = 1'b0;
	hold_clocks(2 * HALF_PHASE);
	scl = 1'b0;
endtask

// Entered with SCL low after an acknowledge clock
task automatic repeated_start();
	hold_clocks(HALF_PHASE);
	sda_host = 1'b1;
	hold_clocks(HALF_PHASE);
	scl = 1'b1;
	hold_clocks(2 * HALF_PHASE);
	start_condition();
endtask

// SDA rises under a high SCL, bus left idle
task automatic stop_condition();
	hold_clocks(HALF_PHASE);
	sda_host = 1'b0;
	hold_clocks(HALF_PHASE);
	scl = 1'b1;
	hold_clocks(2 * HALF_PHASE);
	sda_host = 1'b1;
endtask

// Eight data bits MSB first, then the acknowledge clock
task automatic write_byte(input byte_t value, output logic acked);
	int i;
	for (i = 7; i >= 0; i--) begin
		// Data changes mid low phase, well clear of both SCL edges
		hold_clocks(HALF_PHASE);
		sda_host = value[i];
		hold_clocks(HALF_PHASE);
		scl = 1'b1;
		hold_clocks(2 * HALF_PHASE);
		scl = 1'b0;
	end
	// Release SDA so the target can pull it
	hold_clocks(HALF_PHASE);
	sda_host = 1'b1;
	hold_clocks(HALF_PHASE);
	scl = 1'b1;
	hold_clocks(HALF_PHASE);
	// Low bus in mid high phase means ACK
	acked = ~sda_bus;
	hold_clocks(HALF_PHASE);
	scl = 1'b0;
endtask

// One LCG step yielding a byte from the middle of the state
function automatic byte_t next_random_byte();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return lcg_state[23:16];
endfunction

`default_nettype wire

`endif

// ==== tb/tb_i2c_reg_slave.sv ====
// I2C register slave testbench

`timescale 1ns/1ns
`default_nettype none

module tb_i2c_reg_slave
	import i2c_pkg::*;
();

	localparam logic [ADDR_BITS-1:0] TARGET_ADDR = 7'h2A;
	localparam logic [ADDR_BITS-1:0] OTHER_ADDR = 7'h51;
	localparam int REG_BYTES = 2;
	localparam int REG_BITS = REG_BYTES * BITS_PER_BYTE;
	localparam logic [REG_BITS-1:0] RESET_VALUE = 16'hBEEF;

	// Half of one SCL phase in clocks
	localparam int HALF_PHASE = 10;
	// Stop to reg_out latency bound
	localparam int LATCH_CYCLES = 4;
	localparam int WATCHDOG_CYCLES = 200000;

	logic clk;
	logic reset;
	logic scl;
	logic sda_host;
	logic sda_drive_low;
	logic sda_bus;
	logic [REG_BITS-1:0] reg_out;

	// Model of the register as the host expects it
	logic [REG_BITS-1:0] expected_reg;
	logic [31:0] lcg_state;

	int error_count;
	int check_count;
	int test_count;
	int test_start_errors;

	// Open-drain bus, either side can pull low
	assign sda_bus = sda_host & ~sda_drive_low;

	i2c_reg_slave #(
		.I2C_ADDRESS   (TARGET_ADDR),
		.BYTES_WIDE    (REG_BYTES),
		.DEFAULT_VALUE (RESET_VALUE)
	) i_dut (
		.clk           (clk),
		.reset         (reset),
		.scl           (scl),
		.sda_in        (sda_bus),
		.sda_drive_low (sda_drive_low),
		.reg_out       (reg_out)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Hard limit on the whole run
	initial begin : watchdog
		int cycles;
		for (cycles = 0; cycles < WATCHDOG_CYCLES; cycles++)
			@(posedge clk);
		$display("timeout: scenario sequence did not complete in time");
		$display("*** TEST FAILED ***");
		$finish;
	end

	task automatic check_equal(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		assert (actual === expected) else begin
			$display("error: %s = 0x%h, expected 0x%h", name, actual, expected);
			error_count++;
		end
	endtask

	// Poll for the latched value, bounded by the stop latency
	task automatic expect_latch(input logic [REG_BITS-1:0] expected);
		int n;
		for (n = 0; n < LATCH_CYCLES && reg_out !== expected; n++)
			@(negedge clk);
		check_equal("reg_out", 32'(reg_out), 32'(expected));
	endtask

	// Watch past the latch window for an unwanted update
	task automatic expect_steady(input logic [REG_BITS-1:0] expected);
		int n;
		for (n = 0; n < 2 * LATCH_CYCLES; n++)
			@(negedge clk);
		check_equal("reg_out", 32'(reg_out), 32'(expected));
	endtask

	task automatic report_test(input int number, input string title);
		if (error_count == test_start_errors)
			$display("test %0d %s: ok", number, title);
		else
			$display("test %0d %s: %0d errors", number, title,
				error_count - test_start_errors);
		test_count++;
		test_start_errors = error_count;
	endtask

	initial begin : scenarios
		byte_t first_byte;
		byte_t second_byte;
		byte_t extra_byte;
		logic  acked;

		reset = 1'b1;
		scl = 1'b1;
		sda_host = 1'b1;
		lcg_state = 32'd38;
		error_count = 0;
		check_count = 0;
		test_count = 0;
		test_start_errors = 0;
		expected_reg = RESET_VALUE;
		hold_clocks(4);
		reset = 1'b0;
		hold_clocks(2 * HALF_PHASE);

		check_equal("reg_out", 32'(reg_out), 32'(RESET_VALUE));
		check_equal("sda_drive_low", 32'(sda_drive_low), 32'd0);
		report_test(1, "reset state");

		// Full write, old value must hold until the stop
		first_byte = next_random_byte();
		second_byte = next_random_byte();
		start_condition();
		write_byte({TARGET_ADDR, 1'b0}, acked);
		check_equal("address ack", 32'(acked), 32'd1);
		write_byte(first_byte, acked);
		check_equal("data ack", 32'(acked), 32'd1);
		write_byte(second_byte, acked);
		check_equal("data ack", 32'(acked), 32'd1);
		check_equal("reg_out", 32'(reg_out), 32'(expected_reg));
		stop_condition();
		expected_reg = {first_byte, second_byte};
		expect_latch(expected_reg);
		hold_clocks(2 * HALF_PHASE);
		report_test(2, "two-byte write");

		// Foreign address sees SDA high in every ACK slot
		first_byte = next_random_byte();
		second_byte = next_random_byte();
		start_condition();
		write_byte({OTHER_ADDR, 1'b0}, acked);
		check_equal("address ack", 32'(acked), 32'd0);
		write_byte(first_byte, acked);
		check_equal("data ack", 32'(acked), 32'd0);
		write_byte(second_byte, acked);
		check_equal("data ack", 32'(acked), 32'd0);
		stop_condition();
		expect_steady(expected_reg);
		hold_clocks(2 * HALF_PHASE);
		report_test(3, "other address");

		// Short write is dropped at the stop
		first_byte = next_random_byte();
		start_condition();
		write_byte({TARGET_ADDR, 1'b0}, acked);
		check_equal("address ack", 32'(acked), 32'd1);
		write_byte(first_byte, acked);
		check_equal("data ack", 32'(acked), 32'd1);
		stop_condition();
		expect_steady(expected_reg);
		hold_clocks(2 * HALF_PHASE);
		report_test(4, "single byte then stop");

		// Partial write cut off by a repeated start
		extra_byte = next_random_byte();
		start_condition();
		write_byte({TARGET_ADDR, 1'b0}, acked);
		check_equal("address ack", 32'(acked), 32'd1);
		write_byte(extra_byte, acked);
		check_equal("data ack", 32'(acked), 32'd1);
		repeated_start();
		first_byte = next_random_byte();
		second_byte = next_random_byte();
		write_byte({TARGET_ADDR, 1'b0}, acked);
		check_equal("address ack", 32'(acked), 32'd1);
		write_byte(first_byte, acked);
		check_equal("data ack", 32'(acked), 32'd1);
		write_byte(second_byte, acked);
		check_equal("data ack", 32'(acked), 32'd1);
		stop_condition();
		expected_reg = {first_byte, second_byte};
		expect_latch(expected_reg);
		hold_clocks(2 * HALF_PHASE);
		report_test(5, "repeated start");

		// Third byte past the register width is ignored
		first_byte = next_random_byte();
		second_byte = next_random_byte();
		extra_byte = next_random_byte();
		start_condition();
		write_byte({TARGET_ADDR, 1'b0}, acked);
		check_equal("address ack", 32'(acked), 32'd1);
		write_byte(first_byte, acked);
		check_equal("data ack", 32'(acked), 32'd1);
		write_byte(second_byte, acked);
		check_equal("data ack", 32'(acked), 32'd1);
		write_byte(extra_byte, acked);
		stop_condition();
		expected_reg = {first_byte, second_byte};
		expect_latch(expected_reg);
		expect_steady(expected_reg);
		report_test(6, "three-byte write");

		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
		if (error_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// Host tasks use the bus signals above
	`include "i2c_host_tasks.svh"

endmodule

`default_nettype wire

// ==== hw/i2c_reg_slave.sv ====
// I2C register slave top level

`timescale 1ns/1ns
`default_nettype none

module i2c_reg_slave
	import i2c_pkg::*;
#(
	parameter logic [ADDR_BITS-1:0] I2C_ADDRESS = 7'h2A,
	parameter int BYTES_WIDE = 2,
	parameter logic [BYTES_WIDE*BITS_PER_BYTE-1:0] DEFAULT_VALUE = 16'hBEEF
) (
	input  logic clk,
	input  logic reset,
	input  logic scl,
	input  logic sda_in,
	output logic sda_drive_low,
	output logic [BYTES_WIDE*BITS_PER_BYTE-1:0] reg_out
);

	// Byte stream between bit receiver and register
	logic  start;
	logic  stop;
	logic  wr;
	logic  wr_ack;
	byte_t write_data;

	i2c_byte_serializer i_serializer (
		.clk           (clk),
		.reset         (reset),
		.scl           (scl),
		.sda_in        (sda_in),
		.sda_drive_low (sda_drive_low),
		.start         (start),
		.stop          (stop),
		.write_data    (write_data),
		.wr            (wr),
		.wr_ack        (wr_ack)
	);

	i2c_reg_target #(
		.I2C_ADDRESS   (I2C_ADDRESS),
		.BYTES_WIDE    (BYTES_WIDE),
		.DEFAULT_VALUE (DEFAULT_VALUE)
	) i_target (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.stop       (stop),
		.write_data (write_data),
		.wr         (wr),
		.wr_ack     (wr_ack),
		.reg_out    (reg_out)
	);

endmodule

`default_nettype wire

// ==== hw/i2c_reg_target.sv ====
// I2C multi-byte register target

`timescale 1ns/1ns
`default_nettype none

module i2c_reg_target
	import i2c_pkg::*;
#(
	parameter logic [ADDR_BITS-1:0] I2C_ADDRESS = 7'h00,
	parameter int BYTES_WIDE = 1,
	parameter logic [BYTES_WIDE*BITS_PER_BYTE-1:0] DEFAULT_VALUE = '0
) (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic stop,
	input  byte_t write_data,
	input  logic wr,
	output logic wr_ack,
	output logic [BYTES_WIDE*BITS_PER_BYTE-1:0] reg_out
);

	localparam int BITS_WIDE = BYTES_WIDE * BITS_PER_BYTE;

	// At least one bit even for a single-byte register
	localparam int COUNT_WIDTH = (BYTES_WIDE > 1) ? $clog2(BYTES_WIDE) : 1;
	localparam logic [COUNT_WIDTH-1:0] LAST_BYTE = COUNT_WIDTH'(BYTES_WIDE - 1);

	tgt_state_t state;

	// Data bytes seen in this transaction
	logic [COUNT_WIDTH-1:0] byte_count;

	// New value builds up here until the stop
	logic [BITS_WIDE-1:0] shadow;
	logic shadow_load;

	// Address byte is the 7-bit address above the R/W bit
	logic addr_match;

	assign addr_match = (write_data[7 -: ADDR_BITS] == I2C_ADDRESS);
	assign shadow_load = (state == wait_byte) && wr && !start;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= idle;
			byte_count <= '0;
			wr_ack <= 1'b0;
			reg_out <= DEFAULT_VALUE;
		end else if (start) begin
			// Start or repeated start from any state
			state <= wait_address;
			byte_count <= '0;
			wr_ack <= 1'b0;
		end else begin
			case (state)
				idle: begin
					byte_count <= '0;
					wr_ack <= 1'b0;
				end

				wait_address: begin
					if (stop) begin
						state <= idle;
					end else if (wr) begin
						// NACK anything not for us and sit out the rest
						wr_ack <= addr_match;
						state <= addr_match ? wait_byte : idle;
					end
				end

				wait_byte: begin
					// Early stop drops the partial value
					if (stop) begin
						state <= idle;
					end else if (wr) begin
						wr_ack <= 1'b1;
						if (byte_count == LAST_BYTE) begin
							byte_count <= '0;
							state <= wait_stop;
						end else begin
							byte_count <= byte_count + 1'b1;
						end
					end
				end

				wait_stop: begin
					// Extra bytes are ignored
					if (stop) begin
						reg_out <= shadow;
						state <= idle;
					end
				end

				default: begin
					state <= idle;
				end
			endcase
		end
	end

	// First data byte ends up most significant
	always_ff @(posedge clk) begin
		if (shadow_load)
			shadow <= (shadow << BITS_PER_BYTE) | BITS_WIDE'(write_data);
	end

	// Output register moves only on the latch after a stop
	a_reg_out_on_stop: assert property (
		@(posedge clk) disable iff (reset)
		!$stable(reg_out) |-> $past(stop)
	) else $error("reg_out changed without a stop");

endmodule

`default_nettype wire

// ==== hw/i2c_byte_serializer.sv ====
// I2C bit receiver and byte serializer

`timescale 1ns/1ns
`default_nettype none

module i2c_byte_serializer
	import i2c_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  scl,
	input  logic  sda_in,
	output logic  sda_drive_low,
	output logic  start,
	output logic  stop,
	output byte_t write_data,
	output logic  wr,
	input  logic  wr_ack
);

	// Two flops per pin, idle bus reads high
	logic [1:0] scl_sync;
	logic [1:0] sda_sync;

	// Synchronized pin levels
	logic scl_s;
	logic sda_s;

	// Last synchronized SDA level for edge detection
	logic prev_sda;
	logic sda_fall;
	logic sda_rise;

	// Position in the current 9-clock frame
	logic [3:0] bit_count;

	// High for the one cycle where a data bit is sampled
	logic data_bit_edge;

	ser_state_t state;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			scl_sync <= 2'b11;
			sda_sync <= 2'b11;
			prev_sda <= 1'b1;
		end else begin
			scl_sync <= {scl_sync[0], scl};
			sda_sync <= {sda_sync[0], sda_in};
			prev_sda <= sda_s;
		end
	end

	assign scl_s = scl_sync[1];
	assign sda_s = sda_sync[1];

	// SDA moves while SCL is high only for start and stop
	assign sda_fall = prev_sda & ~sda_s;
	assign sda_rise = ~prev_sda & sda_s;

	// Rising SCL outside the acknowledge clock carries data
	assign data_bit_edge = (state == wait_scl_high) && scl_s &&
		(bit_count != 4'(ACK_SLOT));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= wait_start;
			bit_count <= '0;
			sda_drive_low <= 1'b0;
			start <= 1'b0;
			stop <= 1'b0;
			wr <= 1'b0;
		end else begin
			// Strobes last one cycle
			start <= 1'b0;
			stop <= 1'b0;
			wr <= 1'b0;

			case (state)
				wait_start: begin
					// Bus idle, look for SDA falling under a high SCL
					sda_drive_low <= 1'b0;
					bit_count <= '0;
					if (scl_s && sda_fall) begin
						start <= 1'b1;
						state <= wait_scl_low;
					end
				end

				wait_scl_low: begin
					// SCL high here
					if (!scl_s) begin
						state <= wait_scl_high;
						// Pull SDA ahead of the acknowledge clock so it is settled
						// when SCL rises again
						if (bit_count == 4'(ACK_SLOT))
							sda_drive_low <= wr_ack;
						else
							sda_drive_low <= 1'b0;
					end else if (sda_fall) begin
						// Repeated start, new frame begins with the address
						start <= 1'b1;
						bit_count <= '0;
						sda_drive_low <= 1'b0;
					end else if (sda_rise) begin
						// Stop condition
						stop <= 1'b1;
						sda_drive_low <= 1'b0;
						state <= wait_start;
					end
				end

				wait_scl_high: begin
					// SCL low, the next rise clocks a bit
					if (scl_s) begin
						state <= wait_scl_low;
						if (bit_count == 4'(ACK_SLOT)) begin
							// Acknowledge clock, keep SDA as it is
							bit_count <= '0;
						end else begin
							bit_count <= bit_count + 4'd1;
							// Last data bit completes the byte
							wr <= (bit_count == 4'(BITS_PER_BYTE - 1));
						end
					end
				end

				default: begin
					state <= wait_start;
				end
			endcase
		end
	end

	// MSB first shift register
	always_ff @(posedge clk) begin
		if (data_bit_edge)
			write_data <= {write_data[6:0], sda_s};
	end

	// Start and stop come from opposite SDA edges
	a_start_stop_exclusive: assert property (
		@(posedge clk) disable iff (reset)
		!(start && stop)
	) else $error("start and stop pulsed together");

endmodule

`default_nettype wire

// ==== hw/i2c_pkg.sv ====
// I2C register target shared definitions

`default_nettype none

package i2c_pkg;

	// One byte as it comes off the bus
	typedef logic [7:0] byte_t;

	// Data bits in a frame before the acknowledge clock
	localparam int BITS_PER_BYTE = 8;

	// Bit index of the acknowledge clock within a frame
	localparam int ACK_SLOT = 8;

	// Width of a 7-bit target address
	localparam int ADDR_BITS = 7;

	// Bit-level receiver states
	typedef enum logic [1:0] {
		wait_start,
		wait_scl_low,
		wait_scl_high
	} ser_state_t;

	// Register target transaction states
	typedef enum logic [1:0] {
		idle,
		wait_address,
		wait_byte,
		wait_stop
	} tgt_state_t;

endpackage

`default_nettype wire
